/* Makefile */
# Verilator simulation of the GMII PTP/UDP transmitter

VERILATOR ?= verilator
TOP       ?= tb_gmii_udp_tx
SEED      ?= 51
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP SEED FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
+incdir+hdl
hdl/eth_tx_pkg.sv
hdl/byte_stream_if.sv
hdl/payload_arbiter.sv
hdl/ipv4_udp_header.sv
hdl/frame_builder.sv
hdl/gmii_tx_framer.sv
hdl/gmii_udp_tx.sv
tests/gmii_udp_tx_props.sv
tests/tb_gmii_udp_tx.sv

/* hdl/byte_stream_if.sv */
//******************************
// Byte stream interface
// valid/ready handshake with last marking the final frame byte
//******************************
`timescale 1ns/1ps

interface byte_stream_if ();

    eth_tx_pkg::byte_t data;
    logic              valid;
    logic              ready;
    logic              last;

    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

/* hdl/eth_tx_consts.svh */
//******************************
// Ethernet transmitter constants
// Addresses, ports, EtherTypes, header sizes and GMII framing
//******************************
`ifndef ETH_TX_CONSTS_SVH
`define ETH_TX_CONSTS_SVH

// MAC addresses
`define ETH_LOCAL_MAC       48'h02_00_00_00_00_00
`define ETH_BCAST_MAC       48'hFF_FF_FF_FF_FF_FF

`define ETH_TYPE_PTP        16'h88F7
`define ETH_TYPE_IPV4       16'h0800

// 192.168.1.128 to broadcast
`define IP_SRC_ADDR         {8'd192, 8'd168, 8'd1, 8'd128}
`define IP_DST_ADDR         {8'd255, 8'd255, 8'd255, 8'd255}
`define IP_TTL              8'd64
`define IP_PROTO_UDP        8'd17

`define UDP_SRC_PORT        16'd1234
`define UDP_DST_PORT        16'd5555

// Byte counts
`define ETH_HDR_BYTES       14
`define IP_UDP_HDR_BYTES    28
`define ETH_MIN_DATA_BYTES  60
`define GMII_PREAMBLE_BYTES 7
`define GMII_IFG_CYCLES     12

`endif

/* hdl/eth_tx_pkg.sv */
//******************************
// Ethernet transmitter types
// Frame kind and byte/length types shared by the design
//******************************
package eth_tx_pkg;

    // Selects the EtherType and whether IP/UDP headers are inserted
    typedef enum logic {
        KIND_PTP = 1'b0,
        KIND_UDP = 1'b1
    } frame_kind_e;

    // One stream or GMII byte
    typedef logic [7:0] byte_t;

    // Payload length or IPv4/UDP length field
    typedef logic [15:0] len_t;

endpackage

/* hdl/frame_builder.sv */
//******************************
// Frame builder
// Ethernet header, optional IPv4/UDP header, then payload
//******************************
`timescale 1ns/1ps
`include "eth_tx_consts.svh"

module frame_builder (
    input  logic                    logic_clk,
    input  logic                    arst_n,
    byte_stream_if.sink             in,
    input  eth_tx_pkg::frame_kind_e kind,
    input  eth_tx_pkg::len_t        udp_payload_len,
    byte_stream_if.source           out
);

    typedef enum logic [1:0] {
        PH_ETH,
        PH_IPUDP,
        PH_PAYLOAD
    } phase_e;

    phase_e                      phase;
    logic [4:0]                  cnt;
    eth_tx_pkg::frame_kind_e     kind_q;
    eth_tx_pkg::len_t            len_q;
    logic [15:0]                 eth_type;
    logic [8*`ETH_HDR_BYTES-1:0] eth_hdr;
    eth_tx_pkg::byte_t           eth_byte;
    eth_tx_pkg::byte_t           ip_byte;
    logic                        hdr_accept;
    logic                        first_accept;

    ipv4_udp_header u_ip_hdr (
        .udp_payload_len (len_q),
        .index           (cnt),
        .hdr_byte        (ip_byte)
    );

    // EtherType only read at bytes 12 and 13, after capture
    assign eth_type = (kind_q == eth_tx_pkg::KIND_UDP) ? `ETH_TYPE_IPV4 : `ETH_TYPE_PTP;
    assign eth_hdr  = {`ETH_BCAST_MAC, `ETH_LOCAL_MAC, eth_type};

    always_comb begin
        eth_byte = 8'h00;
        if (cnt < 5'(`ETH_HDR_BYTES)) begin
            eth_byte = eth_hdr[8*(`ETH_HDR_BYTES - 1 - cnt) +: 8];
        end
    end

    // Headers hold the source off, payload passes straight through
    always_comb begin
        out.data  = in.data;
        out.valid = in.valid;
        out.last  = in.last;
        in.ready  = out.ready;
        case (phase)
            PH_ETH: begin
                out.data = eth_byte;
                out.last = 1'b0;
                in.ready = 1'b0;
            end
            PH_IPUDP: begin
                out.data = ip_byte;
                out.last = 1'b0;
                in.ready = 1'b0;
            end
            default: begin
            end
        endcase
    end

    assign hdr_accept   = out.valid && out.ready && (phase != PH_PAYLOAD);
    assign first_accept = hdr_accept && (phase == PH_ETH) && (cnt == 5'd0);

    always_ff @(posedge logic_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase  <= PH_ETH;
            cnt    <= 5'd0;
            kind_q <= eth_tx_pkg::KIND_PTP;
        end else begin
            if (first_accept) begin
                kind_q <= kind;
            end
            case (phase)
                PH_ETH: begin
                    if (hdr_accept) begin
                        if (cnt == 5'(`ETH_HDR_BYTES - 1)) begin
                            cnt   <= 5'd0;
                            phase <= (kind_q == eth_tx_pkg::KIND_UDP) ? PH_IPUDP : PH_PAYLOAD;
                        end else begin
                            cnt <= cnt + 5'd1;
                        end
                    end
                end
                PH_IPUDP: begin
                    if (hdr_accept) begin
                        if (cnt == 5'(`IP_UDP_HDR_BYTES - 1)) begin
                            cnt   <= 5'd0;
                            phase <= PH_PAYLOAD;
                        end else begin
                            cnt <= cnt + 5'd1;
                        end
                    end
                end
                default: begin
                    if (in.valid && in.ready && in.last) begin
                        phase <= PH_ETH;
                    end
                end
            endcase
        end
    end

    // Length is taken together with the first header byte
    always_ff @(posedge logic_clk) begin
        if (first_accept) begin
            len_q <= udp_payload_len;
        end
    end

endmodule

/* hdl/gmii_tx_framer.sv */
//******************************
// GMII transmit framer
// Preamble, padding, FCS and interframe gap onto GMII
//******************************
`timescale 1ns/1ps
`include "eth_tx_consts.svh"

module gmii_tx_framer (
    input  logic              logic_clk,
    input  logic              arst_n,
    byte_stream_if.sink       in,
    output eth_tx_pkg::byte_t gmii_txd,
    output logic              gmii_tx_en,
    output logic              gmii_tx_er
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA,
        ST_PAD,
        ST_FCS,
        ST_GAP
    } state_e;

    state_e      state;
    logic [2:0]  pre_cnt;
    logic [5:0]  data_cnt;
    logic [5:0]  data_cnt_next;
    logic [1:0]  fcs_idx;
    logic [3:0]  gap_cnt;
    logic [31:0] crc;
    logic [31:0] fcs;

    // Reflected CRC-32, one byte per call
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
                                               input eth_tx_pkg::byte_t data);
        logic [31:0] c;
        c = crc_in ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
        return c;
    endfunction

    // Saturates once the minimum length is reached
    assign data_cnt_next = (data_cnt == 6'(`ETH_MIN_DATA_BYTES)) ? data_cnt
                                                                  : data_cnt + 6'd1;
    assign fcs      = ~crc;
    assign in.ready = (state == ST_DATA);

    always_ff @(posedge logic_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_IDLE;
            gmii_txd   <= 8'h00;
            gmii_tx_en <= 1'b0;
            gmii_tx_er <= 1'b0;
            pre_cnt    <= 3'd0;
            data_cnt   <= 6'd0;
            fcs_idx    <= 2'd0;
            gap_cnt    <= 4'd0;
            crc        <= 32'hFFFF_FFFF;
        end else begin
            case (state)
                ST_IDLE: begin
                    gmii_txd   <= 8'h00;
                    gmii_tx_en <= 1'b0;
                    gmii_tx_er <= 1'b0;
                    if (in.valid) begin
                        gmii_txd   <= 8'h55;
                        gmii_tx_en <= 1'b1;
                        pre_cnt    <= 3'd1;
                        data_cnt   <= 6'd0;
                        fcs_idx    <= 2'd0;
                        crc        <= 32'hFFFF_FFFF;
                        state      <= ST_PREAMBLE;
                    end
                end
                ST_PREAMBLE: begin
                    if (pre_cnt == 3'(`GMII_PREAMBLE_BYTES)) begin
                        // SFD
                        gmii_txd <= 8'hD5;
                        state    <= ST_DATA;
                    end else begin
                        gmii_txd <= 8'h55;
                        pre_cnt  <= pre_cnt + 3'd1;
                    end
                end
                ST_DATA: begin
                    data_cnt <= data_cnt_next;
                    if (in.valid) begin
                        gmii_txd <= in.data;
                        crc      <= crc32_byte(crc, in.data);
                        if (in.last) begin
                            state <= (data_cnt_next < 6'(`ETH_MIN_DATA_BYTES)) ? ST_PAD
                                                                              : ST_FCS;
                        end
                    end else begin
                        // Underflow, send a zero byte and mark the frame bad
                        gmii_txd   <= 8'h00;
                        gmii_tx_er <= 1'b1;
                        crc        <= crc32_byte(crc, 8'h00);
                    end
                end
                ST_PAD: begin
                    gmii_txd <= 8'h00;
                    crc      <= crc32_byte(crc, 8'h00);
                    data_cnt <= data_cnt_next;
                    if (data_cnt_next == 6'(`ETH_MIN_DATA_BYTES)) begin
                        state <= ST_FCS;
                    end
                end
                ST_FCS: begin
                    // Least significant byte first
                    gmii_txd <= fcs[8*fcs_idx +: 8];
                    fcs_idx  <= fcs_idx + 2'd1;
                    if (fcs_idx == 2'd3) begin
                        gap_cnt <= 4'd0;
                        state   <= ST_GAP;
                    end
                end
                ST_GAP: begin
                    gmii_txd   <= 8'h00;
                    gmii_tx_en <= 1'b0;
                    gmii_tx_er <= 1'b0;
                    gap_cnt    <= gap_cnt + 4'd1;
                    if (gap_cnt == 4'(`GMII_IFG_CYCLES - 1)) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* hdl/gmii_udp_tx.sv */
//******************************
// GMII PTP/UDP transmitter
// Arbiter, frame builder and GMII framer on one clock
//******************************
`timescale 1ns/1ps

module gmii_udp_tx (
    input  logic              logic_clk,
    input  logic              arst_n,
    input  eth_tx_pkg::byte_t ptp_tdata,
    input  logic              ptp_tvalid,
    input  logic              ptp_tlast,
    output logic              ptp_tready,
    input  eth_tx_pkg::byte_t udp_tdata,
    input  logic              udp_tvalid,
    input  logic              udp_tlast,
    output logic              udp_tready,
    input  eth_tx_pkg::len_t  udp_payload_len,
    output eth_tx_pkg::byte_t gmii_txd,
    output logic              gmii_tx_en,
    output logic              gmii_tx_er
);

    eth_tx_pkg::frame_kind_e kind;

    byte_stream_if arb_if ();
    byte_stream_if frm_if ();

    payload_arbiter u_arbiter (
        .logic_clk  (logic_clk),
        .arst_n     (arst_n),
        .ptp_tdata  (ptp_tdata),
        .ptp_tvalid (ptp_tvalid),
        .ptp_tlast  (ptp_tlast),
        .ptp_tready (ptp_tready),
        .udp_tdata  (udp_tdata),
        .udp_tvalid (udp_tvalid),
        .udp_tlast  (udp_tlast),
        .udp_tready (udp_tready),
        .out        (arb_if.source),
        .kind       (kind)
    );

    frame_builder u_builder (
        .logic_clk       (logic_clk),
        .arst_n          (arst_n),
        .in              (arb_if.sink),
        .kind            (kind),
        .udp_payload_len (udp_payload_len),
        .out             (frm_if.source)
    );

    gmii_tx_framer u_framer (
        .logic_clk  (logic_clk),
        .arst_n     (arst_n),
        .in         (frm_if.sink),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er)
    );

endmodule

/* hdl/ipv4_udp_header.sv */
//******************************
// IPv4 and UDP header generator
// 28 header bytes in network order, IPv4 checksum included
//******************************
`timescale 1ns/1ps
`include "eth_tx_consts.svh"

module ipv4_udp_header (
    input  eth_tx_pkg::len_t  udp_payload_len,
    input  logic [4:0]        index,
    output eth_tx_pkg::byte_t hdr_byte
);

    eth_tx_pkg::len_t               ip_len;
    eth_tx_pkg::len_t               udp_len;
    logic [31:0]                    src_ip;
    logic [31:0]                    dst_ip;
    logic [31:0]                    sum;
    logic [16:0]                    fold;
    logic [15:0]                    csum;
    logic [8*`IP_UDP_HDR_BYTES-1:0] hdr;

    assign src_ip  = `IP_SRC_ADDR;
    assign dst_ip  = `IP_DST_ADDR;
    assign ip_len  = udp_payload_len + 16'(`IP_UDP_HDR_BYTES);
    // 8 byte UDP header
    assign udp_len = udp_payload_len + 16'd8;

    // Identification, flags and checksum words are zero
    assign sum = 32'h0000_4500
               + {16'h0, ip_len}
               + {16'h0, `IP_TTL, `IP_PROTO_UDP}
               + {16'h0, src_ip[31:16]} + {16'h0, src_ip[15:0]}
               + {16'h0, dst_ip[31:16]} + {16'h0, dst_ip[15:0]};

    // End-around carry, the sum stays far below 2^20
    assign fold = {1'b0, sum[15:0]} + {1'b0, sum[31:16]};
    assign csum = ~(fold[15:0] + {15'h0, fold[16]});

    assign hdr = {8'h45, 8'h00, ip_len, 16'h0000, 16'h0000,
                  `IP_TTL, `IP_PROTO_UDP, csum, src_ip, dst_ip,
                  `UDP_SRC_PORT, `UDP_DST_PORT, udp_len, 16'h0000};

    always_comb begin
        hdr_byte = 8'h00;
        if (index < 5'(`IP_UDP_HDR_BYTES)) begin
            hdr_byte = hdr[8*(`IP_UDP_HDR_BYTES - 1 - index) +: 8];
        end
    end

endmodule

/* hdl/payload_arbiter.sv */
//******************************
// Payload arbiter
// Frame-level fixed priority between the PTP and UDP streams
//******************************
`timescale 1ns/1ps

module payload_arbiter (
    input  logic                    logic_clk,
    input  logic                    arst_n,
    input  eth_tx_pkg::byte_t       ptp_tdata,
    input  logic                    ptp_tvalid,
    input  logic                    ptp_tlast,
    output logic                    ptp_tready,
    input  eth_tx_pkg::byte_t       udp_tdata,
    input  logic                    udp_tvalid,
    input  logic                    udp_tlast,
    output logic                    udp_tready,
    byte_stream_if.source           out,
    output eth_tx_pkg::frame_kind_e kind
);

    logic                    locked;
    eth_tx_pkg::frame_kind_e grant;
    eth_tx_pkg::frame_kind_e sel;
    logic                    last_done;

    // PTP wins when idle and both are pending
    always_comb begin
        if (locked) begin
            sel = grant;
        end else if (ptp_tvalid) begin
            sel = eth_tx_pkg::KIND_PTP;
        end else begin
            sel = eth_tx_pkg::KIND_UDP;
        end
    end

    assign out.data  = (sel == eth_tx_pkg::KIND_PTP) ? ptp_tdata  : udp_tdata;
    assign out.valid = (sel == eth_tx_pkg::KIND_PTP) ? ptp_tvalid : udp_tvalid;
    assign out.last  = (sel == eth_tx_pkg::KIND_PTP) ? ptp_tlast  : udp_tlast;

    // Only the granted source sees ready
    assign ptp_tready = (sel == eth_tx_pkg::KIND_PTP) && out.ready;
    assign udp_tready = (sel == eth_tx_pkg::KIND_UDP) && out.ready;

    assign kind      = sel;
    assign last_done = out.valid && out.ready && out.last;

    // Grant is held from the first cycle a frame is presented
    // so the header stage and the payload always agree on the kind
    always_ff @(posedge logic_clk or negedge arst_n) begin
        if (!arst_n) begin
            locked <= 1'b0;
            grant  <= eth_tx_pkg::KIND_PTP;
        end else if (locked) begin
            if (last_done) begin
                locked <= 1'b0;
            end
        end else if (out.valid && !last_done) begin
            locked <= 1'b1;
            grant  <= sel;
        end
    end

endmodule

/* tests/gmii_udp_tx_props.sv */
//******************************
// GMII framer properties
// End of frame, interframe gap, preamble ready
//******************************
`timescale 1ns/1ps
`include "eth_tx_consts.svh"

module gmii_udp_tx_props (
    input logic logic_clk,
    input logic arst_n,
    input logic tx_en,
    input logic tx_er,
    input logic in_ready,
    input logic fcs_phase
);

    // Frame may only end out of the FCS state
    property end_after_fcs;
        @(posedge logic_clk) disable iff (!arst_n)
            $fell(tx_en) |-> $past(fcs_phase, 2);
    endproperty

    property gap_held;
        @(posedge logic_clk) disable iff (!arst_n)
            $fell(tx_en) |-> !tx_en [*`GMII_IFG_CYCLES];
    endproperty

    // Ready low for the seven preamble cycles, high from the SFD on
    property ready_low_in_preamble;
        @(posedge logic_clk) disable iff (!arst_n)
            $rose(tx_en) |-> !in_ready [*`GMII_PREAMBLE_BYTES] ##1 in_ready;
    endproperty

    property er_inside_frame;
        @(posedge logic_clk) disable iff (!arst_n)
            tx_er |-> tx_en;
    endproperty

    a_end_after_fcs: assert property (end_after_fcs)
        else $error("gmii_tx_en fell without an FCS before it");
    a_gap_held: assert property (gap_held)
        else $error("interframe gap shorter than %0d cycles", `GMII_IFG_CYCLES);
    a_ready_low_in_preamble: assert property (ready_low_in_preamble)
        else $error("framer ready wrong around the preamble");
    a_er_inside_frame: assert property (er_inside_frame)
        else $error("gmii_tx_er high outside a frame");

endmodule

/* tests/tb_gmii_udp_tx.sv */
//******************************
// Testbench for the GMII PTP/UDP transmitter
// Drives both payload streams, checks every GMII frame
//******************************
`timescale 1ns/1ps
`include "eth_tx_consts.svh"

module tb_gmii_udp_tx #(
    parameter int SEED = 51
);

    typedef logic [7:0] byte_q_t[$];

    // Frames queued by all tests together
    localparam int FRAME_COUNT = 7;

    logic              logic_clk;
    logic              arst_n;
    eth_tx_pkg::byte_t ptp_tdata;
    logic              ptp_tvalid;
    logic              ptp_tlast;
    logic              ptp_tready;
    eth_tx_pkg::byte_t udp_tdata;
    logic              udp_tvalid;
    logic              udp_tlast;
    logic              udp_tready;
    eth_tx_pkg::len_t  udp_payload_len;
    eth_tx_pkg::byte_t gmii_txd;
    logic              gmii_tx_en;
    logic              gmii_tx_er;

    byte_q_t ptp_pl;
    byte_q_t udp_pl;
    byte_q_t exp_bytes;
    int      exp_len[$];
    bit      exp_bad[$];
    int      frames_queued = 0;
    int      frames_seen = 0;
    int      errors = 0;

    gmii_udp_tx dut0 (
        .logic_clk       (logic_clk),
        .arst_n          (arst_n),
        .ptp_tdata       (ptp_tdata),
        .ptp_tvalid      (ptp_tvalid),
        .ptp_tlast       (ptp_tlast),
        .ptp_tready      (ptp_tready),
        .udp_tdata       (udp_tdata),
        .udp_tvalid      (udp_tvalid),
        .udp_tlast       (udp_tlast),
        .udp_tready      (udp_tready),
        .udp_payload_len (udp_payload_len),
        .gmii_txd        (gmii_txd),
        .gmii_tx_en      (gmii_tx_en),
        .gmii_tx_er      (gmii_tx_er)
    );

    bind gmii_tx_framer gmii_udp_tx_props u_props (
        .logic_clk      (logic_clk),
        .arst_n         (arst_n),
        .tx_en          (gmii_tx_en),
        .tx_er          (gmii_tx_er),
        .in_ready       (in.ready),
        .fcs_phase      (state == ST_FCS)
    );

    always #2 logic_clk = ~logic_clk;

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            stop_on_failure($sformatf("ERR %0t %s got 0x%0h expected 0x%0h",
                                      $time, name, got, exp));
        end
    endtask

    function automatic byte_q_t random_payload(input int n);
        byte_q_t q;
        for (int i = 0; i < n; i++) begin
            q.push_back(8'($urandom));
        end
        return q;
    endfunction

    // Whole GMII frame as it should appear while tx_en is high
    function automatic byte_q_t expected_frame(input eth_tx_pkg::frame_kind_e kind,
                                               input byte_q_t pl);
        byte_q_t         fr;
        byte_q_t         data;
        logic [8*42-1:0] hdr;
        logic [8*20-1:0] iph;
        logic [15:0]     etype;
        logic [15:0]     ip_len;
        logic [15:0]     udp_len;
        logic [15:0]     csum;
        logic [31:0]     sip;
        logic [31:0]     dip;
        logic [31:0]     sum;
        logic [31:0]     crc;
        logic            fb;
        int              n;
        sip = `IP_SRC_ADDR;
        dip = `IP_DST_ADDR;
        if (kind == eth_tx_pkg::KIND_UDP) begin
            etype   = `ETH_TYPE_IPV4;
            ip_len  = 16'(pl.size() + 28);
            udp_len = 16'(pl.size() + 8);
            // One's-complement sum of the ten IPv4 header words, checksum word zero
            iph = {8'h45, 8'h00, ip_len, 32'h0, `IP_TTL, `IP_PROTO_UDP, 16'h0000,
                   sip, dip};
            sum = 32'h0;
            for (int w = 0; w < 10; w++) begin
                sum = sum + {16'h0, iph[16*(9 - w) +: 16]};
            end
            while (sum > 32'h0000_FFFF) begin
                sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
            end
            csum = ~sum[15:0];
            hdr = {`ETH_BCAST_MAC, `ETH_LOCAL_MAC, etype,
                   8'h45, 8'h00, ip_len, 32'h0, `IP_TTL, `IP_PROTO_UDP, csum, sip, dip,
                   `UDP_SRC_PORT, `UDP_DST_PORT, udp_len, 16'h0000};
            n = 42;
        end else begin
            etype = `ETH_TYPE_PTP;
            hdr   = {`ETH_BCAST_MAC, `ETH_LOCAL_MAC, etype, 224'h0};
            n     = 14;
        end
        for (int i = 0; i < n; i++) begin
            data.push_back(hdr[8*(41 - i) +: 8]);
        end
        foreach (pl[i]) begin
            data.push_back(pl[i]);
        end
        while (data.size() < `ETH_MIN_DATA_BYTES) begin
            data.push_back(8'h00);
        end
        // Bitwise reflected CRC-32, LSB of each byte first
        crc = 32'hFFFF_FFFF;
        foreach (data[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[0] ^ data[i][b];
                crc = {1'b0, crc[31:1]} ^ (fb ? 32'hEDB8_8320 : 32'h0);
            end
        end
        crc = ~crc;
        repeat (`GMII_PREAMBLE_BYTES) begin
            fr.push_back(8'h55);
        end
        fr.push_back(8'hD5);
        foreach (data[i]) begin
            fr.push_back(data[i]);
        end
        for (int i = 0; i < 4; i++) begin
            fr.push_back(crc[8*i +: 8]);
        end
        return fr;
    endfunction

    // A bad frame is only checked for tx_er, its bytes are not compared
    task automatic queue_frame(input eth_tx_pkg::frame_kind_e kind, input byte_q_t pl,
                               input bit bad);
        byte_q_t fr;
        if (bad) begin
            exp_len.push_back(0);
        end else begin
            fr = expected_frame(kind, pl);
            foreach (fr[i]) begin
                exp_bytes.push_back(fr[i]);
            end
            exp_len.push_back(fr.size());
        end
        exp_bad.push_back(bad);
        frames_queued++;
    endtask

    task automatic send_ptp();
        int i;
        i = 0;
        @(posedge logic_clk);
        ptp_tdata  <= ptp_pl[0];
        ptp_tlast  <= (ptp_pl.size() == 1);
        ptp_tvalid <= 1'b1;
        while (i < ptp_pl.size()) begin
            @(negedge logic_clk);
            // UDP held off while PTP owns the grant
            check_value("udp_tready", udp_tready, 0);
            if (ptp_tvalid && ptp_tready) begin
                i++;
            end
            @(posedge logic_clk);
            if (i == ptp_pl.size()) begin
                ptp_tvalid <= 1'b0;
                ptp_tlast  <= 1'b0;
            end else begin
                ptp_tdata <= ptp_pl[i];
                ptp_tlast <= (i == ptp_pl.size() - 1);
            end
        end
    endtask

    // Valid drops for one cycle once drop_at bytes were taken, negative for never
    task automatic send_udp(input int drop_at);
        int i;
        bit dropped;
        i       = 0;
        dropped = 1'b0;
        @(posedge logic_clk);
        udp_payload_len <= eth_tx_pkg::len_t'(udp_pl.size());
        udp_tdata       <= udp_pl[0];
        udp_tlast       <= (udp_pl.size() == 1);
        udp_tvalid      <= 1'b1;
        while (i < udp_pl.size()) begin
            @(negedge logic_clk);
            if (udp_tvalid && udp_tready) begin
                check_value("ptp_tready", ptp_tready, 0);
                i++;
            end
            @(posedge logic_clk);
            if (i == udp_pl.size()) begin
                udp_tvalid <= 1'b0;
                udp_tlast  <= 1'b0;
            end else if (i == drop_at && !dropped) begin
                udp_tvalid <= 1'b0;
                dropped = 1'b1;
            end else begin
                udp_tvalid <= 1'b1;
                udp_tdata  <= udp_pl[i];
                udp_tlast  <= (i == udp_pl.size() - 1);
            end
        end
    endtask

    task automatic wait_all_frames();
        while (frames_seen < frames_queued) begin
            @(posedge logic_clk);
        end
    endtask

    // Collects each frame at the falling edge and compares it at its end
    initial begin : monitor
        byte_q_t got;
        int      idle_cycles;
        bit      in_frame;
        bit      er_seen;
        bit      er_dropped;
        bit      bad;
        int      len;
        idle_cycles = 0;
        in_frame    = 1'b0;
        er_seen     = 1'b0;
        er_dropped  = 1'b0;
        forever begin
            @(negedge logic_clk);
            if (gmii_tx_en) begin
                if (!in_frame) begin
                    if (frames_seen > 0 && idle_cycles < `GMII_IFG_CYCLES) begin
                        stop_on_failure($sformatf("Gap of only %0d cycles before frame %0d",
                                                  idle_cycles, frames_seen));
                    end
                    in_frame   = 1'b1;
                    er_seen    = 1'b0;
                    er_dropped = 1'b0;
                    got.delete();
                end
                got.push_back(gmii_txd);
                if (gmii_tx_er) begin
                    er_seen = 1'b1;
                end else if (er_seen) begin
                    er_dropped = 1'b1;
                end
            end else begin
                check_value("gmii_tx_er", gmii_tx_er, 0);
                if (in_frame) begin
                    in_frame    = 1'b0;
                    idle_cycles = 0;
                    if (exp_len.size() == 0) begin
                        stop_on_failure("A frame came out on GMII with none expected");
                    end else begin
                        len = exp_len.pop_front();
                        bad = exp_bad.pop_front();
                        if (bad) begin
                            check_value("gmii_tx_er seen", er_seen, 1);
                            check_value("gmii_tx_er dropped early", er_dropped, 0);
                        end else begin
                            check_value("gmii_tx_er", er_seen, 0);
                            check_value("frame length", got.size(), len);
                            foreach (got[i]) begin
                                check_value($sformatf("gmii_txd[%0d]", i), got[i],
                                            exp_bytes.pop_front());
                            end
                        end
                        frames_seen++;
                    end
                end
                idle_cycles++;
            end
        end
    end

    initial begin : watchdog
        repeat (200 * FRAME_COUNT + 1000) begin
            @(posedge logic_clk);
        end
        stop_on_failure($sformatf("Timeout, %0d of %0d frames seen on GMII",
                                  frames_seen, FRAME_COUNT));
    end

    initial begin : stimulus
        logic_clk       = 1'b0;
        arst_n          = 1'b0;
        ptp_tdata       = 8'h00;
        ptp_tvalid      = 1'b0;
        ptp_tlast       = 1'b0;
        udp_tdata       = 8'h00;
        udp_tvalid      = 1'b0;
        udp_tlast       = 1'b0;
        udp_payload_len = 16'h0000;
        void'($urandom(SEED));
        repeat (8) begin
            @(posedge logic_clk);
        end
        arst_n <= 1'b1;
        repeat (4) begin
            @(posedge logic_clk);
        end

        // Idle outputs after reset
        @(negedge logic_clk);
        check_value("gmii_tx_en", gmii_tx_en, 0);
        check_value("gmii_tx_er", gmii_tx_er, 0);
        check_value("gmii_txd", gmii_txd, 0);
        check_value("ptp_tready", ptp_tready, 0);
        check_value("udp_tready", udp_tready, 0);

        // Short PTP frame gets padded
        ptp_pl = random_payload(10);
        queue_frame(eth_tx_pkg::KIND_PTP, ptp_pl, 1'b0);
        send_ptp();
        wait_all_frames();

        udp_pl = random_payload(20);
        queue_frame(eth_tx_pkg::KIND_UDP, udp_pl, 1'b0);
        send_udp(-1);
        wait_all_frames();

        // Long enough to need no padding
        udp_pl = random_payload($urandom_range(200, 40));
        queue_frame(eth_tx_pkg::KIND_UDP, udp_pl, 1'b0);
        send_udp(-1);
        wait_all_frames();

        // Both offered together, PTP has priority
        ptp_pl = random_payload(16);
        udp_pl = random_payload(24);
        queue_frame(eth_tx_pkg::KIND_PTP, ptp_pl, 1'b0);
        queue_frame(eth_tx_pkg::KIND_UDP, udp_pl, 1'b0);
        fork
            send_ptp();
            send_udp(-1);
        join
        wait_all_frames();

        // Underflow mid-payload, then a clean frame
        udp_pl = random_payload(30);
        queue_frame(eth_tx_pkg::KIND_UDP, udp_pl, 1'b1);
        send_udp(12);
        udp_pl = random_payload(25);
        queue_frame(eth_tx_pkg::KIND_UDP, udp_pl, 1'b0);
        send_udp(-1);
        wait_all_frames();

        repeat (2 * `GMII_IFG_CYCLES) begin
            @(posedge logic_clk);
        end
        if (errors == 0 && exp_bytes.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_on_failure("Expected bytes left over or errors recorded at the end");
        end
    end

endmodule
